// ==== hw/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    // datapath and address width
    localparam int XLEN = 32;
    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // on-chip memory sizes, in words
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // the only system instruction we accept
    localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_sra,
        alu_sltu,
        alu_ne,
        alu_ge
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_imm
    } wb_sel_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    // decoder output, one per instruction
    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      reg_wen;
        wb_sel_e   wb_sel;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      is_ebreak;
        logic      illegal;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } ctrl_t;

    // retire trace record
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            reg_wen;
    } retire_t;

endpackage

`default_nettype wire

// ==== hw/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire rv_core_pkg::alu_op_e         op,
    input  wire logic [rv_core_pkg::XLEN-1:0] src1,
    input  wire logic [rv_core_pkg::XLEN-1:0] src2,
    output logic [rv_core_pkg::XLEN-1:0]      result
);
    import rv_core_pkg::*;

    // shift amount from the low five bits
    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_xor:  result = src1 ^ src2;
            alu_or:   result = src1 | src2;
            alu_and:  result = src1 & src2;
            alu_sll:  result = src1 << shamt;
            // arithmetic shift keeps the sign bit
            alu_sra:  result = $signed(src1) >>> shamt;
            alu_sltu: result = {{(XLEN-1){1'b0}}, src1 < src2};
            // branch compares, 0 or 1
            alu_ne:   result = {{(XLEN-1){1'b0}}, src1 != src2};
            alu_ge:   result = {{(XLEN-1){1'b0}}, $signed(src1) >= $signed(src2)};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire logic                         clk,
    input  wire logic                         wen,
    input  wire logic [4:0]                   waddr,
    input  wire logic [rv_core_pkg::XLEN-1:0] wdata,
    input  wire logic [4:0]                   raddr1,
    input  wire logic [4:0]                   raddr2,
    output logic [rv_core_pkg::XLEN-1:0]      rdata1,
    output logic [rv_core_pkg::XLEN-1:0]      rdata2
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] regs [32];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hw/instruction_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module instruction_memory (
    input  wire logic                            clk,
    input  wire logic                            we,
    input  wire logic [rv_core_pkg::IMEM_AW-1:0] waddr,
    input  wire logic [rv_core_pkg::XLEN-1:0]    wdata,
    input  wire logic [rv_core_pkg::XLEN-1:0]    pc,
    output logic [rv_core_pkg::XLEN-1:0]         inst
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] mem [IMEM_WORDS];
    // word index from the pc, upper bits ignored
    logic [IMEM_AW-1:0] raddr;

    // program load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign raddr = pc[IMEM_AW+1:2];

    // zero-wait fetch
    assign inst = mem[raddr];

endmodule

`default_nettype wire

// ==== hw/data_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_memory (
    input  wire logic                         clk,
    input  wire logic                         read,
    input  wire logic                         write,
    input  wire rv_core_pkg::mem_size_e       size,
    input  wire logic [rv_core_pkg::XLEN-1:0] addr,
    input  wire logic [rv_core_pkg::XLEN-1:0] wdata,
    output logic [rv_core_pkg::XLEN-1:0]      rdata
);
    import rv_core_pkg::*;

    // four byte lanes per word
    logic [3:0][7:0] mem [DMEM_WORDS];

    logic [DMEM_AW-1:0] idx;
    logic [1:0]         offset;
    logic [3:0]         byte_mask;
    logic [3:0][7:0]    wlanes;
    logic [3:0][7:0]    rword;

    assign idx = addr[DMEM_AW+1:2];
    assign offset = addr[1:0];

    // mask and lane shift by access size
    always_comb begin
        case (size)
            size_byte: begin
                byte_mask = 4'b0001 << offset;
                wlanes = wdata << {offset, 3'b000};
            end
            size_half: begin
                byte_mask = 4'b0011 << {offset[1], 1'b0};
                wlanes = wdata << {offset[1], 4'b0000};
            end
            default: begin
                byte_mask = 4'b1111;
                wlanes = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (write && byte_mask[i]) begin
                mem[idx][i] <= wlanes[i];
            end
        end
    end

    assign rword = mem[idx];

    // narrow loads come back zero-extended
    always_comb begin
        if (!read) begin
            rdata = '0;
        end else begin
            case (size)
                size_byte: rdata = {24'b0, rword[offset]};
                size_half: rdata = {16'b0, rword[{offset[1], 1'b1}], rword[{offset[1], 1'b0}]};
                default:   rdata = rword;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  wire logic [rv_core_pkg::XLEN-1:0] inst,
    output rv_core_pkg::ctrl_t               ctrl,
    output logic [rv_core_pkg::XLEN-1:0]     imm
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // immediates, all sign-extended from inst[31]
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // defaults: nop-like, add, alu write-back
        ctrl = '0;
        ctrl.alu_op = alu_add;
        ctrl.wb_sel = wb_alu;
        ctrl.mem_size = size_word;
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.rd = inst[11:7];
        imm = imm_i;

        case (opcode)
            op_lui: begin
                imm = imm_u;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = wb_imm;
            end
            op_auipc: begin
                // pc + U immediate through the adder
                imm = imm_u;
                ctrl.src1_is_pc = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen = 1'b1;
            end
            op_jal: begin
                imm = imm_j;
                ctrl.is_jal = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = wb_pc4;
            end
            op_jalr: begin
                // target rs1 + imm comes out of the alu
                ctrl.src2_is_imm = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = wb_pc4;
                ctrl.illegal = (funct3 != 3'b000);
            end
            op_load: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_sel = wb_mem;
                case (funct3)
                    3'b010: ctrl.mem_size = size_word;
                    3'b100: ctrl.mem_size = size_byte;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_store: begin
                imm = imm_s;
                ctrl.src2_is_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                case (funct3)
                    3'b000: ctrl.mem_size = size_byte;
                    3'b001: ctrl.mem_size = size_half;
                    3'b010: ctrl.mem_size = size_word;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_branch: begin
                // alu compares rs1 and rs2, result 1 means taken
                imm = imm_b;
                ctrl.is_branch = 1'b1;
                case (funct3)
                    3'b001: ctrl.alu_op = alu_ne;
                    3'b101: ctrl.alu_op = alu_ge;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_imm: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b111: ctrl.alu_op = alu_and;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b101: begin
                        // srai only, srli is outside the subset
                        ctrl.alu_op = alu_sra;
                        ctrl.illegal = (funct7 != 7'b0100000);
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_reg: begin
                ctrl.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000000, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    {7'b0000000, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'b0000000, 3'b011}: ctrl.alu_op = alu_sltu;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            op_system: begin
                ctrl.is_ebreak = (inst == EBREAK_WORD);
                ctrl.illegal = (inst != EBREAK_WORD);
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // unknown encodings fall through as pc + 4 with no side effects
        if (ctrl.illegal) begin
            ctrl.reg_wen = 1'b0;
            ctrl.mem_read = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.is_branch = 1'b0;
            ctrl.is_jal = 1'b0;
            ctrl.is_jalr = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core (
    input  wire logic                            clk,
    input  wire logic                            reset,
    input  wire logic                            run,
    input  wire logic                            imem_we,
    input  wire logic [rv_core_pkg::IMEM_AW-1:0] imem_addr,
    input  wire logic [rv_core_pkg::XLEN-1:0]    imem_wdata,
    output logic                                 halted,
    output logic                                 retire_valid,
    output rv_core_pkg::retire_t                 retire
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] imm;
    ctrl_t           ctrl;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_src1;
    logic [XLEN-1:0] alu_src2;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic            active;
    logic            branch_taken;
    logic            reg_we;
    logic            mem_we;

    // one instruction per cycle while running and not halted
    assign active = run && !halted;
    assign reg_we = active && ctrl.reg_wen;
    assign mem_we = active && ctrl.mem_write;

    instruction_memory u_imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .pc    (pc),
        .inst  (inst)
    );

    inst_decoder u_dec (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    register_file u_rf (
        .clk    (clk),
        .wen    (reg_we),
        .waddr  (ctrl.rd),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // auipc uses pc, immediate forms use imm
    assign alu_src1 = ctrl.src1_is_pc ? pc : rs1_data;
    assign alu_src2 = ctrl.src2_is_imm ? imm : rs2_data;

    alu u_alu (
        .op     (ctrl.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // address is rs1 + imm from the alu
    data_memory u_dmem (
        .clk   (clk),
        .read  (ctrl.mem_read),
        .write (mem_we),
        .size  (ctrl.mem_size),
        .addr  (alu_result),
        .wdata (rs2_data),
        .rdata (load_data)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = load_data;
            wb_pc4:  wb_data = pc_plus4;
            wb_imm:  wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

    // next pc: jalr target has bit 0 cleared
    assign branch_taken = ctrl.is_branch && (alu_result == 32'd1);
    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {alu_result[XLEN-1:1], 1'b0};
        end else if (ctrl.is_jal || branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (active) begin
            pc <= next_pc;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (active && ctrl.is_ebreak) begin
            halted <= 1'b1;
        end
    end

    // trace shows this cycle's instruction
    assign retire_valid = active;
    assign retire.pc = pc;
    assign retire.rd = ctrl.reg_wen ? ctrl.rd : 5'd0;
    assign retire.wdata = wb_data;
    assign retire.reg_wen = ctrl.reg_wen;

endmodule

`default_nettype wire

// ==== dv/clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    // 8 ns period
    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held for the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/rv_core_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_core_assertions (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 halted,
    input wire logic                 retire_valid,
    input wire rv_core_pkg::retire_t retire
);
    import rv_core_pkg::*;

    // number of failed assertions so far
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // nothing retires once halted or while in reset
    a_no_retire_stopped : assert property (
        @(posedge clk) retire_valid |-> (!halted && !reset)
    ) else begin
        $error("retire_valid high while halted or in reset");
        fail_count++;
    end

    // fetch is always word aligned
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (reset) retire_valid |-> (retire.pc[1:0] == 2'b00)
    ) else begin
        $error("retire pc %h is not word aligned", retire.pc);
        fail_count++;
    end

    // halt is sticky until reset
    a_halt_sticky : assert property (
        @(posedge clk) disable iff (reset) halted |=> halted
    ) else begin
        $error("halted fell without reset");
        fail_count++;
    end

    // no write, so rd reads zero in the trace
    a_rd_zero_no_write : assert property (
        @(posedge clk) disable iff (reset)
            (retire_valid && !retire.reg_wen) |-> (retire.rd == 5'd0)
    ) else begin
        $error("retire record without write carries rd %0d", retire.rd);
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int STIM_DEPTH = 512;
    localparam int MAX_RECORDS = 128;
    localparam int NUM_TESTS = 6;
    // test 5 is the ebreak record plus the halt checks, test 6 the run gaps
    localparam int HALT_TEST = 5;
    localparam int STALL_TEST = 6;
    localparam int HALT_CHECK_CYCLES = 5;
    localparam int RAND_SEED = 53;

    logic               clk;
    logic               reset;
    logic               run;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [XLEN-1:0]    imem_wdata;
    logic               halted;
    logic               retire_valid;
    retire_t            retire;

    // raw words from the stim file
    logic [31:0] stim_mem [STIM_DEPTH];
    int prog_count;
    int rec_count;
    logic [XLEN-1:0] halt_pc;

    // expected trace
    int              exp_test  [MAX_RECORDS];
    logic [XLEN-1:0] exp_pc    [MAX_RECORDS];
    logic            exp_wen   [MAX_RECORDS];
    logic [4:0]      exp_rd    [MAX_RECORDS];
    logic [XLEN-1:0] exp_wdata [MAX_RECORDS];

    // per test bookkeeping, index 0 unused
    int    checks     [NUM_TESTS+1];
    int    failures   [NUM_TESTS+1];
    bit    reported   [NUM_TESTS+1];
    string test_names [NUM_TESTS+1];

    int rec_idx;
    int cur_test;
    int gap_cycles;
    int setup_errors;
    bit watchdog_armed;
    int watchdog_cycles;
    logic [XLEN-1:0] last_pc;

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    rv_core u_rv_core (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    bind rv_core rv_core_assertions u_rv_core_assertions (
        .clk          (clk),
        .reset        (reset),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    task automatic compare_word(input int t, input string what,
                                input logic [31:0] got, input logic [31:0] want);
        checks[t]++;
        assert (got === want) else begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
            failures[t]++;
        end
    endtask

    task automatic require(input int t, input bit cond, input string msg);
        checks[t]++;
        assert (cond) else begin
            $display("error at %0t: %s", $time, msg);
            failures[t]++;
        end
    endtask

    task automatic report_test(input int t);
        if (t >= 1 && t <= NUM_TESTS && !reported[t]) begin
            reported[t] = 1'b1;
            // a test that never ran counts as failed
            if (checks[t] == 0) begin
                $display("error: test %0d %s ran no checks", t, test_names[t]);
                failures[t]++;
            end
            $display("test %0d %s: %0d checks, %0d failures, %s", t, test_names[t],
                     checks[t], failures[t], (failures[t] == 0) ? "pass" : "fail");
        end
    endtask

    // layout: count, program, count, 5-word records, halt pc
    task automatic read_stim(output bit ok);
        int i;
        int base;
        for (i = 0; i < STIM_DEPTH; i++) begin
            stim_mem[i] = 'x;
        end
        $readmemh("dv/rv_core_stim.txt", stim_mem);
        ok = 1'b0;
        if (!$isunknown(stim_mem[0]) && stim_mem[0] > 0 && stim_mem[0] <= IMEM_WORDS) begin
            prog_count = stim_mem[0];
            base = prog_count + 2;
            if (!$isunknown(stim_mem[prog_count + 1]) &&
                stim_mem[prog_count + 1] <= MAX_RECORDS) begin
                rec_count = stim_mem[prog_count + 1];
                ok = 1'b1;
                for (i = 0; i < rec_count; i++) begin
                    exp_test[i]  = stim_mem[base + 5*i];
                    exp_pc[i]    = stim_mem[base + 5*i + 1];
                    exp_wen[i]   = stim_mem[base + 5*i + 2][0];
                    exp_rd[i]    = stim_mem[base + 5*i + 3][4:0];
                    exp_wdata[i] = stim_mem[base + 5*i + 4];
                    if (exp_test[i] < 1 || exp_test[i] > HALT_TEST) begin
                        ok = 1'b0;
                    end
                end
                halt_pc = stim_mem[base + 5*rec_count];
                if ($isunknown(halt_pc)) begin
                    ok = 1'b0;
                end
            end
        end
    endtask

    // program goes in while run stays low
    task automatic load_program();
        int i;
        for (i = 0; i < prog_count; i++) begin
            @(posedge clk);
            imem_we <= 1'b1;
            imem_addr <= i[IMEM_AW-1:0];
            imem_wdata <= stim_mem[i + 1];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic check_retire();
        int t;
        string tag;
        if (rec_idx >= rec_count) begin
            require(HALT_TEST, 1'b0, $sformatf("retire at pc %h past the trace", retire.pc));
        end else begin
            t = exp_test[rec_idx];
            // moving on to a new test closes the previous one
            if (t != cur_test) begin
                report_test(cur_test);
                cur_test = t;
            end
            tag = $sformatf("record %0d", rec_idx);
            compare_word(t, {tag, " pc"}, retire.pc, exp_pc[rec_idx]);
            compare_word(t, {tag, " reg_wen"}, {31'b0, retire.reg_wen},
                         {31'b0, exp_wen[rec_idx]});
            compare_word(t, {tag, " rd"}, {27'b0, retire.rd}, {27'b0, exp_rd[rec_idx]});
            if (exp_wen[rec_idx]) begin
                compare_word(t, {tag, " wdata"}, retire.wdata, exp_wdata[rec_idx]);
            end
            last_pc = retire.pc;
            rec_idx++;
        end
    endtask

    // drive run on rising edges, sample the trace on falling edges
    task automatic run_program();
        bit done;
        done = 1'b0;
        watchdog_cycles = 4 * rec_count + 50;
        watchdog_armed = 1'b1;
        while (!done) begin
            @(posedge clk);
            // about one cycle in four is a gap
            run <= (($urandom % 4) != 0);
            @(negedge clk);
            if (!run) begin
                gap_cycles++;
                require(STALL_TEST, !retire_valid, "instruction retired during a run-low gap");
            end
            if (retire_valid) begin
                check_retire();
            end
            if (halted === 1'b1) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic check_after_halt();
        // the ebreak test stays open for the halt checks
        if (cur_test != HALT_TEST) begin
            report_test(cur_test);
        end
        cur_test = HALT_TEST;
        compare_word(HALT_TEST, "halt pc", last_pc, halt_pc);
        require(HALT_TEST, rec_idx == rec_count,
                $sformatf("only %0d of %0d records retired before halt", rec_idx, rec_count));
        // run stays high, core must stay quiet
        repeat (HALT_CHECK_CYCLES) begin
            @(posedge clk);
            run <= 1'b1;
            @(negedge clk);
            require(HALT_TEST, !retire_valid, "instruction retired after halt");
            require(HALT_TEST, halted === 1'b1, "halted fell without reset");
        end
        report_test(HALT_TEST);
        require(STALL_TEST, gap_cycles > 0, "no run-low gaps were generated");
        report_test(STALL_TEST);
    endtask

    initial begin
        bit stim_ok;
        int total_checks;
        int total_failures;
        int assert_failures;
        int t;
        run = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        rec_idx = 0;
        cur_test = 0;
        gap_cycles = 0;
        setup_errors = 0;
        watchdog_armed = 1'b0;
        watchdog_cycles = 0;
        last_pc = '0;
        test_names[1] = "alu ops";
        test_names[2] = "upper immediates and x0";
        test_names[3] = "loads and stores";
        test_names[4] = "control flow";
        test_names[5] = "ebreak and halt";
        test_names[6] = "run gaps";
        void'($urandom(RAND_SEED));
        read_stim(stim_ok);
        wait (reset === 1'b0);
        if (stim_ok) begin
            load_program();
            run_program();
            check_after_halt();
        end else begin
            $display("error: stim file dv/rv_core_stim.txt is missing or malformed");
            setup_errors++;
        end
        total_checks = 0;
        total_failures = setup_errors;
        for (t = 1; t <= NUM_TESTS; t++) begin
            report_test(t);
            total_checks += checks[t];
            total_failures += failures[t];
        end
        assert_failures = u_rv_core.u_rv_core_assertions.fail_count;
        $display("totals: %0d checks, %0d failures, %0d assertion failures",
                 total_checks, total_failures, assert_failures);
        if (total_failures == 0 && assert_failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // limit scales with the trace length
    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: core never halted");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
hw/rv_core_pkg.sv
hw/alu.sv
hw/register_file.sv
hw/instruction_memory.sv
hw/data_memory.sv
hw/inst_decoder.sv
hw/rv_core.sv
dv/clock_gen.sv
dv/rv_core_assertions.sv
dv/tb_rv_core.sv

// ==== dv/rv_core_stim.txt ====
// rv_core program and expected retire trace, all values hex
// program: word count, then instruction words from 80000000 upward
00000033
00500093 ffd00113 002081b3 40208233 0020c2b3 0020e333 0020f3b3 00209433
0020b4b3 fff0b513 fff0c593 0f017613 40115693 12345737 00001797 abcde037
00e00833 10000893 11223937 34490913 0128a023 0008a983 0008ca03 0018ca83
0028cb03 0038cb83 002880a3 00189123 006881a3 0008ac03 0038cc83 0028cd03
00289023 0008ad83 00109463 00209463 00100e13 00115463 0020d463 00200e13
00800eef 00300e13 00000f17 00df0fe7 00400e13 00005463 00500e13 00200513
fff50513 fe051ee3 00100073
// trace: record count, then one record per line: test pc reg_wen rd wdata
00000030
1 80000000 1 01 00000005
1 80000004 1 02 fffffffd
1 80000008 1 03 00000002
1 8000000c 1 04 00000008
1 80000010 1 05 fffffff8
1 80000014 1 06 fffffffd
1 80000018 1 07 00000005
1 8000001c 1 08 a0000000
1 80000020 1 09 00000001
1 80000024 1 0a 00000001
1 80000028 1 0b fffffffa
1 8000002c 1 0c 000000f0
1 80000030 1 0d fffffffe
2 80000034 1 0e 12345000
2 80000038 1 0f 80001038
2 8000003c 1 00 abcde000
2 80000040 1 10 12345000
3 80000044 1 11 00000100
3 80000048 1 12 11223000
3 8000004c 1 12 11223344
3 80000050 0 00 00000000
3 80000054 1 13 11223344
3 80000058 1 14 00000044
3 8000005c 1 15 00000033
3 80000060 1 16 00000022
3 80000064 1 17 00000011
3 80000068 0 00 00000000
3 8000006c 0 00 00000000
3 80000070 0 00 00000000
3 80000074 1 18 fd05fd44
3 80000078 1 19 000000fd
3 8000007c 1 1a 00000005
3 80000080 0 00 00000000
3 80000084 1 1b fd05fffd
4 80000088 0 00 00000000
4 8000008c 0 00 00000000
4 80000094 0 00 00000000
4 80000098 0 00 00000000
4 800000a0 1 1d 800000a4
4 800000a8 1 1e 800000a8
4 800000ac 1 1f 800000b0
4 800000b4 0 00 00000000
4 800000bc 1 0a 00000002
4 800000c0 1 0a 00000001
4 800000c4 0 00 00000000
4 800000c0 1 0a 00000000
4 800000c4 0 00 00000000
5 800000c8 0 00 00000000
// pc of the ebreak that halts the core
800000c8
